/* design/mm_pkg.sv */
// shared sizes for the matrix-multiply subsystem
// plus the DMA control state encoding

`default_nettype none

package mm_pkg;

    // matrix dimension, also elements per memory row
    localparam int SA_WIDTH   = 4;
    // signed element width
    localparam int ELEM_W     = 8;
    // signed accumulator width for one C element
    localparam int ACC_W      = 20;

    // external memory port
    localparam int MEM_AW     = 32;
    localparam int MEM_DW     = 32;
    // byte step from one word to the next
    localparam int WORD_BYTES = 4;

    // row buffer index, one word per row
    localparam int BUF_AW     = 2;

    // dma control states
    typedef enum logic [2:0] {
        IDLE,
        READ_AB,
        WAIT_RSP,
        START_MM,
        WAIT_MM,
        WRITE_C
    } dma_state_e;

endpackage

`default_nettype wire

/* design/row_buffer.sv */
// row buffer for one operand matrix
// one write port, one registered read port

`timescale 1ns/10ps
`default_nettype none

module row_buffer (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        wren_i,
    input  wire  [mm_pkg::BUF_AW-1:0]  waddr_i,
    input  wire  [mm_pkg::MEM_DW-1:0]  wdata_i,
    input  wire  [mm_pkg::BUF_AW-1:0]  raddr_i,
    output logic [mm_pkg::MEM_DW-1:0]  rdata_o
);

    import mm_pkg::*;

    // one packed row per word
    logic [MEM_DW-1:0] rows [2**BUF_AW];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < 2**BUF_AW; r++) begin
                rows[r] <= '0;
            end
            rdata_o <= '0;
        end else begin
            if (wren_i) begin
                rows[waddr_i] <= wdata_i;
            end
            // read data lands one cycle after the address
            rdata_o <= rows[raddr_i];
        end
    end

endmodule

`default_nettype wire

/* design/mm_engine.sv */
// multiply engine for C = A x B
// two-stage step pipeline: buffer read, then four parallel MACs
// holds the 16 C accumulators

`timescale 1ns/10ps
`default_nettype none

module mm_engine (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start_i,
    input  wire  [mm_pkg::MEM_DW-1:0]  a_rdata_i,
    input  wire  [mm_pkg::MEM_DW-1:0]  b_rdata_i,
    output logic [mm_pkg::BUF_AW-1:0]  a_raddr_o,
    output logic [mm_pkg::BUF_AW-1:0]  b_raddr_o,
    output logic                       done_o,
    output logic [mm_pkg::SA_WIDTH*mm_pkg::SA_WIDTH*mm_pkg::ACC_W-1:0] acc_o
);

    import mm_pkg::*;

    // step index {i, k}, i major
    logic [2*BUF_AW-1:0]          step;
    logic                         busy;

    // read stage outputs, aligned with buffer data
    logic                         rd_vld;
    logic [2*BUF_AW-1:0]          rd_step;

    logic signed [ELEM_W-1:0]     a_elem;
    logic signed [2*ELEM_W-1:0]   prod [SA_WIDTH];
    logic signed [ACC_W-1:0]      acc  [SA_WIDTH*SA_WIDTH];

    // step counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step <= '0;
        end else if (start_i) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            step <= step + 1'b1;
            // stop after step (3,3)
            if (&step) begin
                busy <= 1'b0;
            end
        end
    end

    // A row i, B row k
    assign a_raddr_o = step[2*BUF_AW-1:BUF_AW];
    assign b_raddr_o = step[BUF_AW-1:0];

    // valid and index follow the read by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld  <= 1'b0;
            rd_step <= '0;
            done_o  <= 1'b0;
        end else begin
            rd_vld  <= busy;
            rd_step <= step;
            // pulse after the last accumulate
            done_o  <= rd_vld && (&rd_step);
        end
    end

    // A(i,k) from row i, times each B(k,j) of row k
    always_comb begin
        a_elem = a_rdata_i[rd_step[BUF_AW-1:0]*ELEM_W +: ELEM_W];
        for (int j = 0; j < SA_WIDTH; j++) begin
            prod[j] = a_elem * $signed(b_rdata_i[j*ELEM_W +: ELEM_W]);
        end
    end

    // accumulators, cleared by start
    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int n = 0; n < SA_WIDTH*SA_WIDTH; n++) begin
                acc[n] <= '0;
            end
        end else if (rd_vld) begin
            // row i of C, all four columns at once
            for (int j = 0; j < SA_WIDTH; j++) begin
                acc[rd_step[2*BUF_AW-1:BUF_AW]*SA_WIDTH + j] <=
                    acc[rd_step[2*BUF_AW-1:BUF_AW]*SA_WIDTH + j] + ACC_W'(prod[j]);
            end
        end
    end

    // flatten, element (i,j) at 4i+j
    always_comb begin
        for (int n = 0; n < SA_WIDTH*SA_WIDTH; n++) begin
            acc_o[n*ACC_W +: ACC_W] = acc[n];
        end
    end

endmodule

`default_nettype wire

/* design/dma_engine.sv */
// DMA control for the matrix multiply
// overlapped A/B row reads into the row buffers, multiply handshake,
// write-back of C one sign-extended element per word

`timescale 1ns/10ps
`default_nettype none

module dma_engine (
    input  wire                        clk,
    input  wire                        rst_n,

    // configuration
    input  wire                        start_i,
    input  wire  [mm_pkg::MEM_AW-1:0]  mat_a_addr_i,
    input  wire  [mm_pkg::MEM_AW-1:0]  mat_b_addr_i,
    input  wire  [mm_pkg::MEM_AW-1:0]  mat_c_addr_i,
    output logic                       done_o,

    // memory read
    output logic                       mem_rd_req_o,
    output logic [mm_pkg::MEM_AW-1:0]  mem_rd_addr_o,
    input  wire                        mem_rd_gnt_i,
    input  wire                        mem_rd_valid_i,
    input  wire  [mm_pkg::MEM_DW-1:0]  mem_rd_data_i,

    // memory write
    output logic                       mem_wr_req_o,
    output logic [mm_pkg::MEM_AW-1:0]  mem_wr_addr_o,
    output logic [mm_pkg::MEM_DW-1:0]  mem_wr_data_o,
    input  wire                        mem_wr_gnt_i,

    // row buffer fill
    output logic                       buf_a_wren_o,
    output logic                       buf_b_wren_o,
    output logic [mm_pkg::BUF_AW-1:0]  buf_waddr_o,
    output logic [mm_pkg::MEM_DW-1:0]  buf_wdata_o,

    // multiply engine
    output logic                       mm_start_o,
    input  wire                        mm_done_i,
    input  wire  [mm_pkg::SA_WIDTH*mm_pkg::SA_WIDTH*mm_pkg::ACC_W-1:0] acc_i
);

    import mm_pkg::*;

    dma_state_e state, state_n;

    // latched base addresses
    logic [MEM_AW-1:0]   a_base;
    logic [MEM_AW-1:0]   b_base;
    logic [MEM_AW-1:0]   c_base;

    // read issue / response counters, msb picks matrix B
    logic [BUF_AW:0]     iss_cnt;
    logic [BUF_AW:0]     rsp_cnt;
    // C element index {i, j}
    logic [2*BUF_AW-1:0] wr_cnt;

    logic                rd_active;
    logic                rd_last_gnt;
    logic                rd_last_rsp;
    logic                wr_last_gnt;
    logic [ACC_W-1:0]    acc_sel;

    assign rd_active   = (state == READ_AB) || (state == WAIT_RSP);
    assign rd_last_gnt = (state == READ_AB) && mem_rd_gnt_i && (&iss_cnt);
    assign rd_last_rsp = rd_active && mem_rd_valid_i && (&rsp_cnt);
    assign wr_last_gnt = (state == WRITE_C) && mem_wr_gnt_i && (&wr_cnt);

    // state register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (start_i) begin
                    state_n = READ_AB;
                end
            end
            // issue all eight row reads back to back
            READ_AB: begin
                if (rd_last_gnt) begin
                    state_n = WAIT_RSP;
                end
            end
            // drain outstanding responses
            WAIT_RSP: begin
                if (rd_last_rsp) begin
                    state_n = START_MM;
                end
            end
            START_MM: begin
                state_n = WAIT_MM;
            end
            WAIT_MM: begin
                if (mm_done_i) begin
                    state_n = WRITE_C;
                end
            end
            WRITE_C: begin
                if (wr_last_gnt) begin
                    state_n = IDLE;
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    // bases taken only when a start is accepted
    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            a_base <= mat_a_addr_i;
            b_base <= mat_b_addr_i;
            c_base <= mat_c_addr_i;
        end
    end

    // counters and done pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_cnt <= '0;
            rsp_cnt <= '0;
            wr_cnt  <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= wr_last_gnt;
            if (state == IDLE) begin
                iss_cnt <= '0;
                rsp_cnt <= '0;
            end else begin
                if (state == READ_AB && mem_rd_gnt_i) begin
                    iss_cnt <= iss_cnt + 1'b1;
                end
                // responses accepted whenever reads are in flight
                if (rd_active && mem_rd_valid_i) begin
                    rsp_cnt <= rsp_cnt + 1'b1;
                end
            end
            if (state == WAIT_MM) begin
                wr_cnt <= '0;
            end else if (state == WRITE_C && mem_wr_gnt_i) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // read request, held until granted
    assign mem_rd_req_o  = (state == READ_AB);
    assign mem_rd_addr_o = (iss_cnt[BUF_AW] ? b_base : a_base)
                           + MEM_AW'(iss_cnt[BUF_AW-1:0]) * MEM_AW'(WORD_BYTES);

    // response steering, written on the response edge
    assign buf_a_wren_o = rd_active && mem_rd_valid_i && !rsp_cnt[BUF_AW];
    assign buf_b_wren_o = rd_active && mem_rd_valid_i &&  rsp_cnt[BUF_AW];
    assign buf_waddr_o  = rsp_cnt[BUF_AW-1:0];
    assign buf_wdata_o  = mem_rd_data_i;

    // single-cycle start to the multiply engine
    assign mm_start_o = (state == START_MM);

    // one C element per write, sign extended
    assign acc_sel       = acc_i[wr_cnt*ACC_W +: ACC_W];
    assign mem_wr_req_o  = (state == WRITE_C);
    assign mem_wr_addr_o = c_base + MEM_AW'(wr_cnt) * MEM_AW'(WORD_BYTES);
    assign mem_wr_data_o = {{(MEM_DW-ACC_W){acc_sel[ACC_W-1]}}, acc_sel};

endmodule

`default_nettype wire

/* design/mat_mul_top.sv */
// matrix-multiply subsystem top
// DMA engine, A and B row buffers, multiply engine

`timescale 1ns/10ps
`default_nettype none

module mat_mul_top (
    input  wire                        clk,
    input  wire                        rst_n,

    // configuration
    input  wire                        start_i,
    input  wire  [mm_pkg::MEM_AW-1:0]  mat_a_addr_i,
    input  wire  [mm_pkg::MEM_AW-1:0]  mat_b_addr_i,
    input  wire  [mm_pkg::MEM_AW-1:0]  mat_c_addr_i,
    output logic                       done_o,

    // memory read
    output logic                       mem_rd_req_o,
    output logic [mm_pkg::MEM_AW-1:0]  mem_rd_addr_o,
    input  wire                        mem_rd_gnt_i,
    input  wire                        mem_rd_valid_i,
    input  wire  [mm_pkg::MEM_DW-1:0]  mem_rd_data_i,

    // memory write
    output logic                       mem_wr_req_o,
    output logic [mm_pkg::MEM_AW-1:0]  mem_wr_addr_o,
    output logic [mm_pkg::MEM_DW-1:0]  mem_wr_data_o,
    input  wire                        mem_wr_gnt_i
);

    import mm_pkg::*;

    // buffer fill, shared address and data
    logic                              buf_a_wren;
    logic                              buf_b_wren;
    logic [BUF_AW-1:0]                 buf_waddr;
    logic [MEM_DW-1:0]                 buf_wdata;

    // buffer read side
    logic [BUF_AW-1:0]                 buf_a_raddr;
    logic [BUF_AW-1:0]                 buf_b_raddr;
    logic [MEM_DW-1:0]                 buf_a_rdata;
    logic [MEM_DW-1:0]                 buf_b_rdata;

    // multiply handshake and results
    logic                              mm_start;
    logic                              mm_done;
    logic [SA_WIDTH*SA_WIDTH*ACC_W-1:0] acc_flat;

    dma_engine u_dma (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .mat_a_addr_i   (mat_a_addr_i),
        .mat_b_addr_i   (mat_b_addr_i),
        .mat_c_addr_i   (mat_c_addr_i),
        .done_o         (done_o),
        .mem_rd_req_o   (mem_rd_req_o),
        .mem_rd_addr_o  (mem_rd_addr_o),
        .mem_rd_gnt_i   (mem_rd_gnt_i),
        .mem_rd_valid_i (mem_rd_valid_i),
        .mem_rd_data_i  (mem_rd_data_i),
        .mem_wr_req_o   (mem_wr_req_o),
        .mem_wr_addr_o  (mem_wr_addr_o),
        .mem_wr_data_o  (mem_wr_data_o),
        .mem_wr_gnt_i   (mem_wr_gnt_i),
        .buf_a_wren_o   (buf_a_wren),
        .buf_b_wren_o   (buf_b_wren),
        .buf_waddr_o    (buf_waddr),
        .buf_wdata_o    (buf_wdata),
        .mm_start_o     (mm_start),
        .mm_done_i      (mm_done),
        .acc_i          (acc_flat)
    );

    // matrix A rows
    row_buffer u_buf_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .wren_i  (buf_a_wren),
        .waddr_i (buf_waddr),
        .wdata_i (buf_wdata),
        .raddr_i (buf_a_raddr),
        .rdata_o (buf_a_rdata)
    );

    // matrix B rows
    row_buffer u_buf_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .wren_i  (buf_b_wren),
        .waddr_i (buf_waddr),
        .wdata_i (buf_wdata),
        .raddr_i (buf_b_raddr),
        .rdata_o (buf_b_rdata)
    );

    mm_engine u_mm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mm_start),
        .a_rdata_i (buf_a_rdata),
        .b_rdata_i (buf_b_rdata),
        .a_raddr_o (buf_a_raddr),
        .b_raddr_o (buf_b_raddr),
        .done_o    (mm_done),
        .acc_o     (acc_flat)
    );

endmodule

`default_nettype wire

/* tb/tb_mem_model.sv */
// behavioral external memory for the testbench
// random grants, in-order reads with random latency, write counter

`timescale 1ns/10ps
`default_nettype none

module tb_mem_model (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         rd_req_i,
    input  wire  [31:0] rd_addr_i,
    output logic        rd_gnt_o,
    output logic        rd_valid_o,
    output logic [31:0] rd_data_o,
    input  wire         wr_req_i,
    input  wire  [31:0] wr_addr_i,
    input  wire  [31:0] wr_data_i,
    output logic        wr_gnt_o
);

    // sparse word store
    logic [31:0] mem [logic [31:0]];
    // accepted reads, oldest first
    logic [31:0] pend_addr [$];
    int          pend_due  [$];
    int          cycle;
    int          lat;
    int          wr_count;
    integer      seed;
    logic [31:0] rsp_addr;

    initial begin
        seed       = 32'hd367_b337;
        cycle      = 0;
        wr_count   = 0;
        rd_gnt_o   <= 1'b0;
        rd_valid_o <= 1'b0;
        rd_data_o  <= '0;
        wr_gnt_o   <= 1'b0;
    end

    // preload one word
    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr] = data;
    endtask

    // all outputs move on the falling edge
    always @(negedge clk) begin
        cycle = cycle + 1;
        rd_gnt_o   <= 1'b0;
        rd_valid_o <= 1'b0;
        wr_gnt_o   <= 1'b0;
        if (rst_n) begin
            // grant given here is taken at the next rising edge
            if (rd_req_i && (($random(seed) & 3) != 0)) begin
                lat = 1 + int'($unsigned($random(seed)) % 6);
                rd_gnt_o <= 1'b1;
                pend_addr.push_back(rd_addr_i);
                pend_due.push_back(cycle + lat);
            end
            // oldest read first, once its latency has run out
            if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
                rsp_addr = pend_addr.pop_front();
                void'(pend_due.pop_front());
                rd_valid_o <= 1'b1;
                // unwritten words read back as the inverted address
                rd_data_o  <= mem.exists(rsp_addr) ? mem[rsp_addr] : ~rsp_addr;
            end
            if (wr_req_i && (($random(seed) & 3) != 0)) begin
                wr_gnt_o <= 1'b1;
                mem[wr_addr_i] = wr_data_i;
                wr_count = wr_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_mat_mul.sv */
// testbench for the matrix-multiply subsystem
// random A/B operands and bases, integer reference model,
// bus monitor for reads, writes and the done pulse

`timescale 1ns/10ps
`default_nettype none

module tb_mat_mul;

    localparam int NUM_OPS  = 8;
    localparam int DONE_TMO = 2000;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [31:0] a_addr;
    logic [31:0] b_addr;
    logic [31:0] c_addr;
    wire         done;
    wire         rd_req;
    wire  [31:0] rd_addr;
    wire         rd_gnt;
    wire         rd_valid;
    wire  [31:0] rd_data;
    wire         wr_req;
    wire  [31:0] wr_addr;
    wire  [31:0] wr_data;
    wire         wr_gnt;

    integer      seed;
    int          ctl_err;

    // expected traffic of the current operation
    logic [31:0] exp_rd_addr [8];
    logic [31:0] exp_wr_addr [16];
    logic [31:0] exp_wr_data [16];

    // monitor counters summed over all operations
    int          rd_acc_cnt   = 0;
    int          rd_rsp_cnt   = 0;
    int          wr_acc_cnt   = 0;
    int          done_cnt     = 0;
    int          rd_err       = 0;
    int          wr_err       = 0;
    int          seq_err      = 0;
    logic        prev_rd_req  = 1'b0;
    logic [31:0] prev_rd_addr = '0;
    logic        prev_wr_req  = 1'b0;
    logic [31:0] prev_wr_addr = '0;
    logic [31:0] prev_wr_data = '0;

    always #50 clk = ~clk;

    mat_mul_top mat_mul_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start),
        .mat_a_addr_i   (a_addr),
        .mat_b_addr_i   (b_addr),
        .mat_c_addr_i   (c_addr),
        .done_o         (done),
        .mem_rd_req_o   (rd_req),
        .mem_rd_addr_o  (rd_addr),
        .mem_rd_gnt_i   (rd_gnt),
        .mem_rd_valid_i (rd_valid),
        .mem_rd_data_i  (rd_data),
        .mem_wr_req_o   (wr_req),
        .mem_wr_addr_o  (wr_addr),
        .mem_wr_data_o  (wr_data),
        .mem_wr_gnt_i   (wr_gnt)
    );

    tb_mem_model mem_model_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_req_i   (rd_req),
        .rd_addr_i  (rd_addr),
        .rd_gnt_o   (rd_gnt),
        .rd_valid_o (rd_valid),
        .rd_data_o  (rd_data),
        .wr_req_i   (wr_req),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data),
        .wr_gnt_o   (wr_gnt)
    );

    // gnt and valid still hold what the last rising edge saw
    // as the memory updates them nonblocking on this edge
    always @(negedge clk) begin
        if (prev_rd_req && rd_gnt) begin
            if (prev_rd_addr !== exp_rd_addr[rd_acc_cnt % 8]) begin
                $display("** Error mem_rd_addr_o: 0x%h, expected 0x%h",
                         prev_rd_addr, exp_rd_addr[rd_acc_cnt % 8]);
                rd_err++;
            end
            rd_acc_cnt++;
        end else if (prev_rd_req) begin
            // request must hold through a withheld grant
            if (!rd_req) begin
                $display("read request dropped without a grant");
                rd_err++;
            end
            if (rd_addr !== prev_rd_addr) begin
                $display("** Error mem_rd_addr_o: 0x%h, held 0x%h", rd_addr, prev_rd_addr);
                rd_err++;
            end
        end
        if (rd_valid) begin
            rd_rsp_cnt++;
        end
        if (prev_wr_req && wr_gnt) begin
            if (prev_wr_addr !== exp_wr_addr[wr_acc_cnt % 16]) begin
                $display("** Error mem_wr_addr_o: 0x%h, expected 0x%h",
                         prev_wr_addr, exp_wr_addr[wr_acc_cnt % 16]);
                wr_err++;
            end
            if (prev_wr_data !== exp_wr_data[wr_acc_cnt % 16]) begin
                $display("** Error mem_wr_data_o: 0x%h, expected 0x%h",
                         prev_wr_data, exp_wr_data[wr_acc_cnt % 16]);
                wr_err++;
            end
            wr_acc_cnt++;
        end else if (prev_wr_req) begin
            if (!wr_req) begin
                $display("write request dropped without a grant");
                wr_err++;
            end
            if (wr_addr !== prev_wr_addr) begin
                $display("** Error mem_wr_addr_o: 0x%h, held 0x%h", wr_addr, prev_wr_addr);
                wr_err++;
            end
            if (wr_data !== prev_wr_data) begin
                $display("** Error mem_wr_data_o: 0x%h, held 0x%h", wr_data, prev_wr_data);
                wr_err++;
            end
        end
        // writes of operation n need all 8(n+1) responses first
        if (wr_req && rd_rsp_cnt < 8 * (wr_acc_cnt / 16 + 1)) begin
            $display("write requested before the eighth read response");
            seq_err++;
        end
        if (done) begin
            done_cnt++;
            if (wr_acc_cnt != 16 * done_cnt) begin
                $display("done pulse without sixteen granted writes");
                seq_err++;
            end
        end
        prev_rd_req  = rd_req;
        prev_rd_addr = rd_addr;
        prev_wr_req  = wr_req;
        prev_wr_addr = wr_addr;
        prev_wr_data = wr_data;
    end

    // ops 0 and 1 all extreme and later ops mostly random
    function automatic logic signed [7:0] random_elem(input int op);
        int r;
        r = $random(seed) & 7;
        if (op == 0 || (op > 1 && r == 0)) begin
            return -8'sd128;
        end else if (op == 1 || r == 1) begin
            return 8'sd127;
        end
        return 8'($random(seed));
    endfunction

    task automatic run_op(input int op, output bit ok);
        logic signed [7:0] a [4][4];
        logic signed [7:0] b [4][4];
        int                c;
        int                cycles;
        @(negedge clk);
        // regions of A, B and C never overlap
        a_addr = 32'h1000_0000 | ($random(seed) & 32'h00ff_fff0);
        b_addr = 32'h2000_0000 | ($random(seed) & 32'h00ff_fff0);
        c_addr = 32'h3000_0000 | ($random(seed) & 32'h00ff_ffc0);
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 4; k++) begin
                a[i][k] = random_elem(op);
                b[i][k] = random_elem(op);
            end
        end
        // row r with element 0 in the low byte
        for (int r = 0; r < 4; r++) begin
            mem_model_inst.load_word(a_addr + 32'(4 * r), {a[r][3], a[r][2], a[r][1], a[r][0]});
            mem_model_inst.load_word(b_addr + 32'(4 * r), {b[r][3], b[r][2], b[r][1], b[r][0]});
            exp_rd_addr[r]     = a_addr + 32'(4 * r);
            exp_rd_addr[4 + r] = b_addr + 32'(4 * r);
        end
        // reference C in integer arithmetic
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                c = 0;
                for (int k = 0; k < 4; k++) begin
                    c = c + int'(a[i][k]) * int'(b[k][j]);
                end
                exp_wr_addr[4 * i + j] = c_addr + 32'(4 * (4 * i + j));
                exp_wr_data[4 * i + j] = c;
            end
        end
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // bases only count at start so the inputs may wander afterwards
        a_addr = $random(seed);
        b_addr = $random(seed);
        c_addr = $random(seed);
        cycles = 0;
        while (!done && cycles < DONE_TMO) begin
            @(negedge clk);
            cycles++;
        end
        ok = done;
        if (!done) begin
            $display("timeout: no done pulse within %0d cycles in operation %0d", DONE_TMO, op);
            ctl_err++;
        end else begin
            // the monitor has run on this edge by the next rising edge
            @(posedge clk);
            if (rd_acc_cnt != 8 * (op + 1) || rd_rsp_cnt != 8 * (op + 1)) begin
                $display("operation %0d: %0d reads and %0d responses in total, expected %0d",
                         op, rd_acc_cnt, rd_rsp_cnt, 8 * (op + 1));
                ctl_err++;
            end
            if (wr_acc_cnt != 16 * (op + 1) || mem_model_inst.wr_count != 16 * (op + 1)) begin
                $display("operation %0d: %0d writes in total, expected %0d",
                         op, wr_acc_cnt, 16 * (op + 1));
                ctl_err++;
            end
            if (done_cnt != op + 1) begin
                $display("operation %0d: %0d done pulses in total", op, done_cnt);
                ctl_err++;
            end
        end
    endtask

    task automatic finish_run();
        int total;
        total = rd_err + wr_err + seq_err + ctl_err;
        $display("read errors %0d, write errors %0d, sequence errors %0d, control errors %0d",
                 rd_err, wr_err, seq_err, ctl_err);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    initial begin
        bit ok;
        seed    = 32'hd367_b337;
        ctl_err = 0;
        clk     = 1'b0;
        rst_n   = 1'b0;
        start   = 1'b0;
        a_addr  = '0;
        b_addr  = '0;
        c_addr  = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        // idle with start low
        repeat (20) begin
            @(negedge clk);
            if (done || rd_req || wr_req) begin
                $display("output active after reset while start is low");
                ctl_err++;
            end
        end
        ok = 1'b1;
        for (int op = 0; op < NUM_OPS && ok; op++) begin
            run_op(op, ok);
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* vlog.f */
design/mm_pkg.sv
design/row_buffer.sv
design/mm_engine.sv
design/dma_engine.sv
design/mat_mul_top.sv
tb/tb_mem_model.sv
tb/tb_mat_mul.sv

/* run_sim.sh */
#!/bin/sh
# build and run the matrix-multiply testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal --top-module tb_mat_mul -f vlog.f -o tb_mat_mul
out="$(./obj_dir/tb_mat_mul)"
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
